// ==== Makefile ====
# Verilator build and run for the PMP checker

VERILATOR  ?= verilator
TOP        := pmp_checker_tb
RTL_TOP    := pmp_checker
FILELIST   := build.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall

SOURCES := $(wildcard source/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+dv
source/pmp_pkg.sv
source/pmp_csr_bank.sv
source/pmp_region_match.sv
source/pmp_access_decide.sv
source/pmp_checker.sv
dv/pmp_checker_tb.sv

// ==== dv/pmp_ref.svh ====
// PMP reference model
`ifndef PMP_REF_SVH
`define PMP_REF_SVH

// Shadow copies of every register write
logic [CFG_W-1:0] shadow_cfg  [NUM_REG];
logic [CSR_W-1:0] shadow_addr [NUM_REG];
logic             shadow_mmwp;

int mismatch_errors = 0;
int protocol_errors = 0;

function automatic void shadow_clear();
  for (int r = 0; r < NUM_REG; r++) begin
    shadow_cfg[r]  = '0;
    shadow_addr[r] = '0;
  end
  shadow_mmwp = 1'b0;
endfunction

function automatic void shadow_write(input pmp_csr_sel_e sel, input int idx,
                                     input logic [CSR_W-1:0] data);
  case (sel)
    PMP_CSR_CFG:     if (idx < NUM_REG) shadow_cfg[idx] = data[CFG_W-1:0];
    PMP_CSR_ADDR:    if (idx < NUM_REG) shadow_addr[idx] = data;
    PMP_CSR_MSECCFG: shadow_mmwp = data[1];
    default:         ;
  endcase
endfunction

// Expected response packed as allowed, matched, index
function automatic logic [IDX_W+1:0] ref_expect(input logic [ADDR_W-1:0] addr,
                                                input pmp_acc_e acc, input priv_lvl_e priv);
  logic [CSR_W-1:0] word;
  logic [CSR_W-1:0] lo;
  logic [CSR_W-1:0] na;
  logic [CSR_W-1:0] mask;
  logic [CFG_W-1:0] cfg;
  logic             hit;
  logic             found;
  logic             perm;
  logic             allowed;
  logic [IDX_W-1:0] idx;
  int               z;

  word  = addr[ADDR_W-1:2];
  found = 1'b0;
  idx   = '0;
  for (int r = 0; r < NUM_REG; r++) begin
    if (r == 0) lo = '0;
    else lo = shadow_addr[r-1];
    case (pmp_mode_e'(shadow_cfg[r][CFG_MODE_LSB +: 2]))
      PMP_MODE_NA4: hit = (shadow_addr[r] == word);
      PMP_MODE_TOR: hit = ((lo >> GRAN) <= (word >> GRAN)) &&
                          ((word >> GRAN) < (shadow_addr[r] >> GRAN));
      PMP_MODE_NAPOT: begin
        na = shadow_addr[r];
        if (GRAN >= 2) begin
          na = na | ((CSR_W'(1) << (GRAN - 1)) - CSR_W'(1));
        end
        // Count trailing ones to find the region size
        z = 0;
        while (z < CSR_W && na[z]) begin
          z++;
        end
        mask = {CSR_W{1'b1}} << (z + 1);
        mask = mask & ({CSR_W{1'b1}} << GRAN);
        hit  = ((na & mask) == (word & mask));
      end
      default: hit = 1'b0;
    endcase
    if (hit && !found) begin
      found = 1'b1;
      idx   = IDX_W'(r);
    end
  end

  cfg = shadow_cfg[idx];
  case (acc)
    PMP_ACC_READ:  perm = cfg[CFG_R_BIT];
    PMP_ACC_WRITE: perm = cfg[CFG_W_BIT];
    PMP_ACC_EXEC:  perm = cfg[CFG_X_BIT];
    default:       perm = 1'b0;
  endcase
  if (!found) allowed = (priv == PRIV_LVL_M) && !shadow_mmwp;
  else if (priv == PRIV_LVL_M && !cfg[CFG_LOCK_BIT]) allowed = 1'b1;
  else allowed = perm;
  return {allowed, found, idx};
endfunction

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    mismatch_errors++;
  end
endtask

task automatic check_idx(input logic [IDX_W-1:0] got, input logic [IDX_W-1:0] exp,
                         input string what);
  if (got !== exp) begin
    $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    mismatch_errors++;
  end
endtask

`endif

// ==== dv/pmp_checker_tb.sv ====
// PMP checker testbench

`timescale 1ns/10ps
`default_nettype none

module pmp_checker_tb;

  import pmp_pkg::*;

  localparam int          NUM_REG      = 16;
  localparam int          GRAN         = 2;
  localparam int          IDX_W        = $clog2(NUM_REG);
  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 4;
  localparam int unsigned SEED         = 32'hd1fe_0b98;
  // Upper bound on directed writes and requests
  localparam int          DIRECTED_OPS = 256;
  localparam int          RAND_CYCLES  = 400;

  logic                  clk;
  logic                  rst_n_i;
  logic                  csr_we_i;
  pmp_csr_sel_e          csr_sel_i;
  logic [IDX_W-1:0]      csr_idx_i;
  logic [CSR_W-1:0]      csr_wdata_i;
  logic                  req_valid_i;
  logic [ADDR_W-1:0]     req_addr_i;
  pmp_acc_e              req_type_i;
  priv_lvl_e             req_priv_i;
  logic                  resp_valid_o;
  logic                  resp_allowed_o;
  logic                  resp_matched_o;
  logic [IDX_W-1:0]      resp_idx_o;

  // Expected responses and the cycle of each request
  logic [IDX_W+1:0]      exp_q[$];
  int                    stamp_q[$];
  int                    cycle_cnt = 0;

  `include "pmp_ref.svh"

  pmp_checker #(
    .NUM_REGIONS (NUM_REG),
    .GRANULARITY (GRAN)
  ) uut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .csr_we_i       (csr_we_i),
    .csr_sel_i      (csr_sel_i),
    .csr_idx_i      (csr_idx_i),
    .csr_wdata_i    (csr_wdata_i),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .req_type_i     (req_type_i),
    .req_priv_i     (req_priv_i),
    .resp_valid_o   (resp_valid_o),
    .resp_allowed_o (resp_allowed_o),
    .resp_matched_o (resp_matched_o),
    .resp_idx_o     (resp_idx_o)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------

  // One cycle of traffic, driven after a falling edge
  task automatic drive_cycle(input logic wr, input pmp_csr_sel_e sel, input int idx,
                             input logic [CSR_W-1:0] data, input logic rq,
                             input logic [ADDR_W-1:0] addr, input pmp_acc_e acc,
                             input priv_lvl_e priv);
    // A same-cycle write is not yet visible to the request
    if (rq) begin
      exp_q.push_back(ref_expect(addr, acc, priv));
      stamp_q.push_back(cycle_cnt);
    end
    if (wr) shadow_write(sel, idx, data);
    csr_we_i    = wr;
    csr_sel_i   = sel;
    csr_idx_i   = IDX_W'(idx);
    csr_wdata_i = data;
    req_valid_i = rq;
    req_addr_i  = addr;
    req_type_i  = acc;
    req_priv_i  = priv;
    @(negedge clk);
    csr_we_i    = 1'b0;
    req_valid_i = 1'b0;
  endtask

  task automatic csr_write(input pmp_csr_sel_e sel, input int idx, input logic [CSR_W-1:0] data);
    drive_cycle(1'b1, sel, idx, data, 1'b0, '0, PMP_ACC_READ, PRIV_LVL_U);
  endtask

  task automatic send_req(input logic [ADDR_W-1:0] addr, input pmp_acc_e acc,
                          input priv_lvl_e priv);
    drive_cycle(1'b0, PMP_CSR_CFG, 0, '0, 1'b1, addr, acc, priv);
  endtask

  // Every access type from both privilege levels
  task automatic probe(input logic [ADDR_W-1:0] addr);
    for (int p = 0; p < 2; p++) begin
      for (int a = 0; a < 3; a++) begin
        send_req(addr, pmp_acc_e'(2'(a)), (p == 0) ? PRIV_LVL_U : PRIV_LVL_M);
      end
    end
  endtask

  // One word inside and outside each end of [lo, hi)
  task automatic probe_edges(input logic [ADDR_W-1:0] lo, input logic [ADDR_W-1:0] hi);
    probe(lo - ADDR_W'(4));
    probe(lo);
    probe(hi - ADDR_W'(4));
    probe(hi);
  endtask

  task automatic random_traffic(input int n);
    logic              wr;
    logic              rq;
    pmp_csr_sel_e      sel;
    int                pick;
    logic [CSR_W-1:0]  data;
    logic [ADDR_W-1:0] addr;

    for (int k = 0; k < n; k++) begin
      rq   = ($urandom_range(0, 3) != 0);
      wr   = ($urandom_range(0, 4) == 0);
      pick = $urandom_range(0, 9);
      sel  = (pick < 5) ? PMP_CSR_ADDR : (pick < 9) ? PMP_CSR_CFG : PMP_CSR_MSECCFG;
      if (sel == PMP_CSR_ADDR && $urandom_range(0, 1) == 0) data = $urandom_range(0, 32'h7fff);
      else if (sel == PMP_CSR_ADDR) data = $urandom;
      else data = $urandom_range(0, 255);
      // Bias addresses towards programmed regions
      case ($urandom_range(0, 3))
        0:       addr = ADDR_W'({$urandom, $urandom});
        1:       addr = ADDR_W'($urandom_range(0, 32'h1_ffff));
        2:       addr = 34'h2_0000_0000 + ADDR_W'($urandom_range(0, 32'h1_ffff));
        default: addr = {shadow_addr[$urandom_range(0, NUM_REG - 1)], 2'b00} +
                        ADDR_W'($urandom_range(0, 63)) - ADDR_W'(32);
      endcase
      drive_cycle(wr, sel, $urandom_range(0, NUM_REG - 1), data, rq, addr,
                  pmp_acc_e'(2'($urandom_range(0, 2))),
                  ($urandom_range(0, 1) == 0) ? PRIV_LVL_U : PRIV_LVL_M);
    end
  endtask

  // ----------------------------------------
  // Response checking
  // ----------------------------------------

  initial begin : resp_monitor
    logic [IDX_W+1:0] exp;
    int               stamp;

    forever begin
      @(negedge clk);
      if (resp_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t ns: response arrived with no request outstanding", $time);
          protocol_errors++;
        end else begin
          exp   = exp_q.pop_front();
          stamp = stamp_q.pop_front();
          check_bit(resp_allowed_o, exp[IDX_W+1],
                    $sformatf("resp_allowed_o for request in cycle %0d", stamp));
          check_bit(resp_matched_o, exp[IDX_W],
                    $sformatf("resp_matched_o for request in cycle %0d", stamp));
          check_idx(resp_idx_o, exp[IDX_W-1:0],
                    $sformatf("resp_idx_o for request in cycle %0d", stamp));
        end
      end else if (stamp_q.size() != 0 && stamp_q[0] < cycle_cnt) begin
        $display("Error at %0t ns: no response to the request in cycle %0d", $time, stamp_q[0]);
        protocol_errors++;
        void'(exp_q.pop_front());
        void'(stamp_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    #((DIRECTED_OPS + RAND_CYCLES + 50) * CLK_PERIOD);
    $display("Error: watchdog expired before the tests finished");
    $display("test failed");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin : stimulus
    void'($urandom(SEED));
    shadow_clear();
    rst_n_i     = 1'b0;
    csr_we_i    = 1'b0;
    csr_sel_i   = PMP_CSR_CFG;
    csr_idx_i   = '0;
    csr_wdata_i = '0;
    // A machine-mode request held through reset must leave no response behind
    req_valid_i = 1'b1;
    req_addr_i  = '0;
    req_type_i  = PMP_ACC_READ;
    req_priv_i  = PRIV_LVL_M;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i     = 1'b1;
    req_valid_i = 1'b0;
    check_bit(resp_valid_o, 1'b0, "resp_valid_o after reset");
    check_bit(resp_allowed_o, 1'b0, "resp_allowed_o after reset");
    probe(34'h1_2345_6780);

    // NA4 word at 0x2000 read and write, NAPOT 4 KiB execute only
    csr_write(PMP_CSR_ADDR, 3, 32'h0000_0800);
    csr_write(PMP_CSR_CFG, 3, 32'h13);
    csr_write(PMP_CSR_ADDR, 5, 32'h0000_11ff);
    csr_write(PMP_CSR_CFG, 5, 32'h1c);
    // NAPOT 64 KiB at 0x2_0000_0000, read only
    csr_write(PMP_CSR_ADDR, 6, 32'h8000_1fff);
    csr_write(PMP_CSR_CFG, 6, 32'h19);
    probe_edges(34'h0_0000_2000, 34'h0_0000_2004);
    probe_edges(34'h0_0000_4000, 34'h0_0000_5000);
    probe_edges(34'h2_0000_0000, 34'h2_0001_0000);

    // TOR 0x8000 to 0x9000, both bounds rounded down to the granule
    csr_write(PMP_CSR_ADDR, 7, 32'h0000_2003);
    csr_write(PMP_CSR_ADDR, 8, 32'h0000_2402);
    csr_write(PMP_CSR_CFG, 8, 32'h09);
    csr_write(PMP_CSR_ADDR, 0, 32'h0000_0400);
    csr_write(PMP_CSR_CFG, 0, 32'h0f);
    probe_edges(34'h0_0000_8000, 34'h0_0000_9000);
    probe_edges(34'h0_0000_0000, 34'h0_0000_1000);

    // Region 10 grants everything below 64 KiB but loses to lower indexes
    csr_write(PMP_CSR_ADDR, 10, 32'h0000_1fff);
    csr_write(PMP_CSR_CFG, 10, 32'h1f);
    probe(34'h0_0000_2000);
    probe(34'h0_0000_4000);
    probe(34'h0_0000_6000);

    // Lock region 3, then whitelist policy on and off
    csr_write(PMP_CSR_CFG, 3, 32'h93);
    probe_edges(34'h0_0000_2000, 34'h0_0000_2004);
    csr_write(PMP_CSR_MSECCFG, 0, 32'h2);
    probe(34'h3_0000_0000);
    probe(34'h0_0000_2000);
    csr_write(PMP_CSR_MSECCFG, 0, 32'h0);
    probe(34'h3_0000_0000);

    random_traffic(RAND_CYCLES);
    repeat (3) @(negedge clk);
    if (stamp_q.size() != 0) begin
      $display("Error: %0d responses never arrived", stamp_q.size());
      protocol_errors++;
    end

    $display("errors: %0d mismatches, %0d protocol errors", mismatch_errors, protocol_errors);
    if (mismatch_errors == 0 && protocol_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/pmp_access_decide.sv ====
// PMP access decision stage

`timescale 1ns/10ps
`default_nettype none

module pmp_access_decide #(
  parameter int  NUM_REGIONS = 16,
  localparam int IDX_W       = (NUM_REGIONS > 1) ? $clog2(NUM_REGIONS) : 1
) (
  input  wire                                  clk,
  input  wire                                  rst_n_i,

  // Request, sampled at the edge
  input  wire                                  req_valid_i,
  input  wire pmp_pkg::pmp_acc_e               req_type_i,
  input  wire pmp_pkg::priv_lvl_e              req_priv_i,

  // Matcher and register bank
  input  wire [NUM_REGIONS-1:0]                match_i,
  input  wire [NUM_REGIONS*pmp_pkg::CFG_W-1:0] cfg_flat_i,
  input  wire                                  mmwp_i,

  // Registered response
  output logic                                 resp_valid_o,
  output logic                                 resp_allowed_o,
  output logic                                 resp_matched_o,
  output logic [IDX_W-1:0]                     resp_idx_o
);

  import pmp_pkg::*;

  logic             hit;
  logic [IDX_W-1:0] hit_idx;
  logic [CFG_W-1:0] hit_cfg;
  logic             perm_ok;
  logic             allowed;

  // ----------------------------------------
  // Priority select
  // ----------------------------------------

  // Scan from the top down so the lowest matching index is the last one kept
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int r = NUM_REGIONS - 1; r >= 0; r--) begin
      if (match_i[r]) begin
        hit     = 1'b1;
        hit_idx = IDX_W'(r);
      end
    end
  end

  assign hit_cfg = cfg_flat_i[int'(hit_idx)*CFG_W +: CFG_W];

  // Permission bit for this request type
  always_comb begin
    case (req_type_i)
      PMP_ACC_READ:  perm_ok = hit_cfg[CFG_R_BIT];
      PMP_ACC_WRITE: perm_ok = hit_cfg[CFG_W_BIT];
      PMP_ACC_EXEC:  perm_ok = hit_cfg[CFG_X_BIT];
      default:       perm_ok = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Access rules
  // ----------------------------------------

  // Any level other than M is treated as user mode
  always_comb begin
    if (hit) begin
      if (req_priv_i == PRIV_LVL_M) begin
        // Unlocked regions do not restrict M-mode
        allowed = !hit_cfg[CFG_LOCK_BIT] || perm_ok;
      end else begin
        allowed = perm_ok;
      end
    end else begin
      // No match: M-mode only, and only when the whitelist policy is off
      allowed = (req_priv_i == PRIV_LVL_M) && !mmwp_i;
    end
  end

  // ----------------------------------------
  // Response register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      resp_valid_o   <= 1'b0;
      resp_allowed_o <= 1'b0;
      resp_matched_o <= 1'b0;
      resp_idx_o     <= '0;
    end else begin
      resp_valid_o <= req_valid_i;
      // result holds until the next request
      if (req_valid_i) begin
        resp_allowed_o <= allowed;
        resp_matched_o <= hit;
        resp_idx_o     <= hit_idx;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/pmp_checker.sv ====
// PMP checker top level

`timescale 1ns/10ps
`default_nettype none

module pmp_checker #(
  parameter int  NUM_REGIONS = 16,
  parameter int  GRANULARITY = 2,
  localparam int IDX_W       = (NUM_REGIONS > 1) ? $clog2(NUM_REGIONS) : 1
) (
  input  wire                         clk,
  input  wire                         rst_n_i,

  // Register write port
  input  wire                         csr_we_i,
  input  wire pmp_pkg::pmp_csr_sel_e  csr_sel_i,
  input  wire [IDX_W-1:0]             csr_idx_i,
  input  wire [pmp_pkg::CSR_W-1:0]    csr_wdata_i,

  // Access request
  input  wire                         req_valid_i,
  input  wire [pmp_pkg::ADDR_W-1:0]   req_addr_i,
  input  wire pmp_pkg::pmp_acc_e      req_type_i,
  input  wire pmp_pkg::priv_lvl_e     req_priv_i,

  // Response, one cycle after the request
  output logic                        resp_valid_o,
  output logic                        resp_allowed_o,
  output logic                        resp_matched_o,
  output logic [IDX_W-1:0]            resp_idx_o
);

  import pmp_pkg::*;

  logic [NUM_REGIONS*CFG_W-1:0] cfg_flat;
  logic [NUM_REGIONS*CSR_W-1:0] addr_flat;
  logic                         mmwp;
  logic [NUM_REGIONS-1:0]       match;

  pmp_csr_bank #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_csr_bank (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_idx_i   (csr_idx_i),
    .csr_wdata_i (csr_wdata_i),
    .cfg_flat_o  (cfg_flat),
    .addr_flat_o (addr_flat),
    .mmwp_o      (mmwp)
  );

  // Same-cycle match against the live register contents
  pmp_region_match #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) u_region_match (
    .cfg_flat_i  (cfg_flat),
    .addr_flat_i (addr_flat),
    .req_addr_i  (req_addr_i),
    .match_o     (match)
  );

  pmp_access_decide #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_access_decide (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_type_i     (req_type_i),
    .req_priv_i     (req_priv_i),
    .match_i        (match),
    .cfg_flat_i     (cfg_flat),
    .mmwp_i         (mmwp),
    .resp_valid_o   (resp_valid_o),
    .resp_allowed_o (resp_allowed_o),
    .resp_matched_o (resp_matched_o),
    .resp_idx_o     (resp_idx_o)
  );

endmodule

`default_nettype wire

// ==== source/pmp_csr_bank.sv ====
// PMP register bank

`timescale 1ns/10ps
`default_nettype none

module pmp_csr_bank #(
  parameter int  NUM_REGIONS = 16,
  localparam int IDX_W       = (NUM_REGIONS > 1) ? $clog2(NUM_REGIONS) : 1
) (
  input  wire                                   clk,
  input  wire                                   rst_n_i,

  // Write port
  input  wire                                   csr_we_i,
  input  wire pmp_pkg::pmp_csr_sel_e            csr_sel_i,
  input  wire [IDX_W-1:0]                       csr_idx_i,
  input  wire [pmp_pkg::CSR_W-1:0]              csr_wdata_i,

  // Register contents
  output logic [NUM_REGIONS*pmp_pkg::CFG_W-1:0] cfg_flat_o,
  output logic [NUM_REGIONS*pmp_pkg::CSR_W-1:0] addr_flat_o,
  output logic                                  mmwp_o
);

  import pmp_pkg::*;

  // mmwp position inside the mseccfg write word
  localparam int MMWP_BIT = 1;

  logic cfg_sel;
  logic addr_sel;
  logic mmwp_we;

  // Opcode decode, shared by every region
  assign cfg_sel  = csr_we_i && (csr_sel_i == PMP_CSR_CFG);
  assign addr_sel = csr_we_i && (csr_sel_i == PMP_CSR_ADDR);
  assign mmwp_we  = csr_we_i && (csr_sel_i == PMP_CSR_MSECCFG);

  // ----------------------------------------
  // Per-region registers
  // ----------------------------------------

  for (genvar r = 0; r < NUM_REGIONS; r++) begin : g_region
    logic             idx_hit;
    logic [CFG_W-1:0] cfg_q;
    logic [CSR_W-1:0] addr_q;

    // An index at or above NUM_REGIONS hits no region, so the write is dropped
    assign idx_hit = (csr_idx_i == IDX_W'(r));

    always_ff @(posedge clk) begin
      if (!rst_n_i) begin
        cfg_q  <= '0;
        addr_q <= '0;
      end else begin
        if (cfg_sel && idx_hit) begin
          cfg_q <= csr_wdata_i[CFG_W-1:0];
        end
        if (addr_sel && idx_hit) begin
          addr_q <= csr_wdata_i;
        end
      end
    end

    assign cfg_flat_o[r*CFG_W +: CFG_W]  = cfg_q;
    assign addr_flat_o[r*CSR_W +: CSR_W] = addr_q;
  end

  // ----------------------------------------
  // Policy bit
  // ----------------------------------------

  // Index is ignored for mseccfg
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mmwp_o <= 1'b0;
    end else if (mmwp_we) begin
      mmwp_o <= csr_wdata_i[MMWP_BIT];
    end
  end

endmodule

`default_nettype wire

// ==== source/pmp_pkg.sv ====
// PMP checker shared definitions

`default_nettype none

package pmp_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Physical request address
  localparam int ADDR_W = 34;

  // Address register and write data, request bits 33:2
  localparam int CSR_W = 32;

  // One region configuration byte
  localparam int CFG_W = 8;

  // ----------------------------------------
  // Configuration byte layout
  // ----------------------------------------

  localparam int CFG_R_BIT    = 0;
  localparam int CFG_W_BIT    = 1;
  localparam int CFG_X_BIT    = 2;
  // Two-bit address mode field, bits 4:3
  localparam int CFG_MODE_LSB = 3;
  localparam int CFG_LOCK_BIT = 7;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------

  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'd0,
    PMP_MODE_TOR   = 2'd1,
    PMP_MODE_NA4   = 2'd2,
    PMP_MODE_NAPOT = 2'd3
  } pmp_mode_e;

  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'd0,
    PMP_ACC_WRITE = 2'd1,
    PMP_ACC_EXEC  = 2'd2
  } pmp_acc_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // Write target of the register port
  typedef enum logic [1:0] {
    PMP_CSR_CFG     = 2'd0,
    PMP_CSR_ADDR    = 2'd1,
    PMP_CSR_MSECCFG = 2'd2
  } pmp_csr_sel_e;

endpackage

`default_nettype wire

// ==== source/pmp_region_match.sv ====
// PMP region address matcher

`timescale 1ns/10ps
`default_nettype none

module pmp_region_match #(
  parameter int NUM_REGIONS = 16,
  parameter int GRANULARITY = 2
) (
  input  wire [NUM_REGIONS*pmp_pkg::CFG_W-1:0] cfg_flat_i,
  input  wire [NUM_REGIONS*pmp_pkg::CSR_W-1:0] addr_flat_i,
  input  wire [pmp_pkg::ADDR_W-1:0]            req_addr_i,
  output logic [NUM_REGIONS-1:0]               match_o
);

  import pmp_pkg::*;

  // Width of a word address once granularity bits are dropped
  localparam int CUT_W = CSR_W - GRANULARITY;

  // Low G mask bits, always cleared for NAPOT
  localparam logic [CSR_W-1:0] G_CLR  = (CSR_W'(1) << GRANULARITY) - CSR_W'(1);
  // Low G-1 address bits, forced to one for NAPOT
  localparam logic [CSR_W-1:0] G_FILL = G_CLR >> 1;

  logic [CSR_W-1:0] req_word;
  logic [CUT_W-1:0] req_cut;

  // Request as a word address, bits 33:2
  assign req_word = req_addr_i[ADDR_W-1:2];
  assign req_cut  = req_word[CSR_W-1:GRANULARITY];

  // ----------------------------------------
  // Per-region match, all in parallel
  // ----------------------------------------

  for (genvar r = 0; r < NUM_REGIONS; r++) begin : g_region
    logic [CFG_W-1:0] cfg;
    logic [CSR_W-1:0] addr;
    logic [CSR_W-1:0] lo_addr;
    logic [CSR_W-1:0] napot_addr;
    logic [CSR_W-1:0] napot_mask;
    pmp_mode_e        mode;
    logic             na4_hit;
    logic             tor_hit;
    logic             napot_hit;
    logic             hit;

    assign cfg  = cfg_flat_i[r*CFG_W +: CFG_W];
    assign addr = addr_flat_i[r*CSR_W +: CSR_W];
    assign mode = pmp_mode_e'(cfg[CFG_MODE_LSB +: $bits(pmp_mode_e)]);

    // TOR lower bound is the region below, zero for region 0
    if (r == 0) begin : g_base
      assign lo_addr = '0;
    end else begin : g_prev
      assign lo_addr = addr_flat_i[(r-1)*CSR_W +: CSR_W];
    end

    // NA4 compares the full word
    assign na4_hit = (addr == req_word);

    // Upper bound exclusive
    assign tor_hit = (lo_addr[CSR_W-1:GRANULARITY] <= req_cut) &&
                     (req_cut < addr[CSR_W-1:GRANULARITY]);

    assign napot_addr = addr | G_FILL;

    // Adding one flips the trailing ones and the lowest zero;
    // xor marks exactly those bits, which the mask must clear
    assign napot_mask = ~(napot_addr ^ (napot_addr + CSR_W'(1))) & ~G_CLR;

    assign napot_hit = ((napot_addr & napot_mask) == (req_word & napot_mask));

    always_comb begin
      case (mode)
        PMP_MODE_TOR:   hit = tor_hit;
        PMP_MODE_NA4:   hit = na4_hit;
        PMP_MODE_NAPOT: hit = napot_hit;
        default:        hit = 1'b0;
      endcase
    end

    assign match_o[r] = hit;
  end

endmodule

`default_nettype wire
